//--- flist.f
hw/fpu_pkg.sv
hw/fp_add_ctrl.sv
hw/fp_add_align.sv
hw/fp_add_sum.sv
hw/fp_add_normalize.sv
hw/fp_add_top.sv
tests/fp_add_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fp_add_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/fp_add_tb.sv
module fp_add_tb import fpu_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   // items per test also size the timeout
   localparam int OUT_CREDITS = 2;
   localparam int N_ADD = 200;
   localparam int N_SUB = 200;
   localparam int N_EXC = 40;
   localparam int N_BP = 150;
   localparam int N_RATE = 100;
   localparam int LIMIT = (1 + N_ADD + N_SUB + N_EXC + N_BP + N_RATE) * 4 + 200;

   logic        clk;
   logic        rst = 1'b1;
   logic [31:0] a_in = '0;
   logic [31:0] b_in = '0;
   fp_op_e      op_in = op_add;
   logic        in_valid = 1'b0;
   logic        out_credit = 1'b0;
   logic        in_credit;
   logic [31:0] sum_out;
   logic        overflow_out;
   logic        out_valid;

   logic [31:0] lfsr = 32'h8c9d8aef;
   // pending stimulus as {op, a, b} then expected {overflow, result} and issue cycle
   logic [64:0] stim_q[$];
   logic [32:0] exp_q[$];
   int          cyc_q[$];
   string       test_name = "reset";
   int          cycle_cnt, src_credits, dut_credits, owed, hold_cnt, last_out;
   int          sent_total, done_total, accepted, credit_pulses;
   int          val_errs, proto_errs, sink_errs, credit_viol, end_errs;
   bit          sink_random, check_latency, check_rate, rate_seen;

   fp_add_top #(
      .OUT_CREDITS (OUT_CREDITS)
   ) fp_add_top_inst (
      .clk          (clk),
      .rst          (rst),
      .a_in         (a_in),
      .b_in         (b_in),
      .op_in        (op_in),
      .in_valid     (in_valid),
      .out_credit   (out_credit),
      .in_credit    (in_credit),
      .sum_out      (sum_out),
      .overflow_out (overflow_out),
      .out_valid    (out_valid)
   );

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   // expected {overflow, result} worked out from the field rules
   function automatic logic [32:0] fp_add_ref(input logic [31:0] a, input logic [31:0] b,
                                              input fp_op_e op);
      logic   sa;
      logic   sb;
      logic   sign;
      int     ea;
      int     eb;
      int     e;
      longint fa;
      longint fb;
      longint mag;
      sa = a[31];
      sb = b[31] ^ (op == op_sub);
      ea = a[30:23];
      eb = b[30:23];
      // hidden one on every exponent with two guard bits below
      fa = {1'b1, a[22:0], 2'b00};
      fb = {1'b1, b[22:0], 2'b00};
      e = (ea >= eb) ? ea : eb;
      if (ea >= eb)
         fb = (ea - eb >= 26) ? 0 : (fb >> (ea - eb));
      else
         fa = (eb - ea >= 26) ? 0 : (fa >> (eb - ea));
      // bigger magnitude wins the sign on a subtract
      sign = (sa == sb || fa >= fb) ? sa : sb;
      mag = (sa == sb) ? fa + fb : ((fa >= fb) ? fa - fb : fb - fa);
      if (mag == 0)
         return 33'h0;
      if (mag >= (64'd1 << 26)) begin
         mag = mag >> 1;
         e = e + 1;
      end
      while (mag < (64'd1 << 25)) begin
         mag = mag << 1;
         e = e - 1;
      end
      if (e >= 255)
         return {1'b1, sign, 8'hff, 23'h0};
      if (e <= 0)
         return {1'b0, sign, 31'h0};
      return {1'b0, sign, 8'(e), 23'(mag >> 2)};
   endfunction

   function automatic logic [31:0] make_fp(input logic s, input int e);
      return {s, 8'(e), 23'(rand_bits(23))};
   endfunction

   task automatic queue_input(input logic [31:0] a, input logic [31:0] b, input fp_op_e op);
      stim_q.push_back({op, a, b});
      sent_total++;
   endtask

   // kind 0 gives same sign adds and kind 1 effective subtracts while others mix freely
   task automatic queue_random(input int kind);
      logic [31:0] a;
      logic [31:0] b;
      int          gap;
      fp_op_e      op;
      case (rand_bits(2))
         0: gap = 0;
         1: gap = rand_bits(3);
         2: gap = 26 + rand_bits(2);
         default: gap = rand_bits(6);
      endcase
      a = make_fp(rand_bits(1), 100 + rand_bits(6));
      b = make_fp(rand_bits(1), a[30:23] - gap);
      op = fp_op_e'(rand_bits(1));
      if (kind == 0) begin
         op = op_add;
         b[31] = a[31];
      end
      if (kind == 1)
         b[31] = a[31] ^ (op == op_add);
      // now and then identical magnitudes for exact cancellation
      if (kind == 1 && rand_bits(3) == 0)
         b[30:0] = a[30:0];
      if (rand_bits(1))
         queue_input(b, a, op);
      else
         queue_input(a, b, op);
   endtask

   task automatic queue_extreme(input bit over);
      logic [31:0] a;
      logic [31:0] b;
      if (over) begin
         // top exponent with a carry saturates
         a = make_fp(rand_bits(1), 254);
         b = make_fp(a[31], 254 - rand_bits(1));
         queue_input(a, b, op_add);
      end else begin
         // tiny near-equal pair cancels below exponent 1
         a = make_fp(rand_bits(1), 1 + rand_bits(2));
         b = a ^ 32'(rand_bits(4));
         queue_input(a, b, op_sub);
      end
   endtask

   task automatic wait_drain();
      while (done_total < sent_total)
         @(posedge clk);
      @(posedge clk);
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
      cycle_cnt <= cycle_cnt + 1;

   initial begin
      wait (cycle_cnt >= LIMIT);
      $display("timeout, run still busy after %0d cycles", LIMIT);
      $display("FAIL: see errors above");
      $finish;
   end

   // source spends a credit per item and takes credits back from in_credit
   always @(negedge clk) begin
      logic [64:0] item;
      if (rst) begin
         src_credits = 3;
         in_valid = 1'b0;
      end else begin
         // a credit returned this cycle is usable on the same edge
         if (in_credit === 1'b1)
            src_credits++;
         if (stim_q.size() != 0 && src_credits > 0) begin
            item = stim_q.pop_front();
            op_in = fp_op_e'(item[64]);
            a_in = item[63:32];
            b_in = item[31:0];
            in_valid = 1'b1;
            src_credits--;
            exp_q.push_back(fp_add_ref(item[63:32], item[31:0], fp_op_e'(item[64])));
            cyc_q.push_back(cycle_cnt);
         end else begin
            in_valid = 1'b0;
         end
      end
   end

   // at most three items between acceptance and their result leaving
   always @(posedge clk) begin
      if (!rst && in_valid) begin
         if (accepted - done_total >= 3) begin
            $display("source raised in_valid while holding no credit");
            credit_viol++;
         end
         accepted++;
      end
   end

   // sink returns one credit per result and stalls at random when asked
   always @(negedge clk) begin
      logic grant;
      if (rst) begin
         out_credit = 1'b0;
         dut_credits = OUT_CREDITS;
         owed = 0;
         hold_cnt = 0;
      end else begin
         if (out_valid === 1'b1) begin
            if (dut_credits == 0) begin
               $display("out_valid raised while the DUT holds no credit");
               sink_errs++;
            end
            owed++;
         end
         grant = 1'b0;
         if (sink_random && hold_cnt > 0)
            hold_cnt--;
         else if (owed > 0)
            grant = 1'b1;
         if (!sink_random)
            hold_cnt = 0;
         else if (hold_cnt == 0 && rand_bits(2) == 0)
            hold_cnt = rand_bits(3);
         owed = owed - int'(grant);
         out_credit = grant;
         dut_credits = dut_credits + int'(grant) - int'(out_valid === 1'b1);
      end
   end

   // compare each result against the oldest expected value
   always @(negedge clk) begin
      logic [32:0] want;
      int          issued;
      if (!rst) begin
         if (in_credit !== out_valid) begin
            $display("in_credit pulse does not match out_valid");
            proto_errs++;
         end
         if (in_credit === 1'b1)
            credit_pulses++;
         if (!check_rate)
            rate_seen = 0;
         if (out_valid === 1'b1) begin
            done_total++;
            // an item driven on this very edge cannot be the result
            if (cyc_q.size() == 0 || cyc_q[0] >= cycle_cnt) begin
               $display("result %h arrived with no input outstanding", sum_out);
               proto_errs++;
            end else begin
               want = exp_q.pop_front();
               issued = cyc_q.pop_front();
               if (sum_out !== want[31:0]) begin
                  $display("ERR %s: sum expected %h actual %h", test_name, want[31:0], sum_out);
                  val_errs++;
               end
               if (overflow_out !== want[32]) begin
                  $display("ERR %s: overflow expected %b actual %b", test_name, want[32],
                           overflow_out);
                  val_errs++;
               end
               if (check_latency && cycle_cnt - issued != 3) begin
                  $display("ERR %s: latency expected 3 actual %0d", test_name, cycle_cnt - issued);
                  val_errs++;
               end
               if (check_rate && rate_seen && cycle_cnt != last_out + 1) begin
                  $display("result stream stalled for %0d cycles", cycle_cnt - last_out - 1);
                  proto_errs++;
               end
               rate_seen = 1;
               last_out = cycle_cnt;
            end
         end
      end
   end

   initial begin
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // idle pipeline first where nothing may come out
      repeat (8) @(posedge clk);
      check_latency = 1;
      queue_input(make_fp(1'b0, 127), make_fp(1'b0, 126), op_add);
      wait_drain();
      check_latency = 0;
      test_name = "same_sign_add";
      repeat (N_ADD) queue_random(0);
      wait_drain();
      test_name = "subtract_cancel";
      repeat (N_SUB) queue_random(1);
      wait_drain();
      test_name = "overflow_underflow";
      for (int i = 0; i < N_EXC; i++)
         queue_extreme(i % 2 == 0);
      wait_drain();
      test_name = "back_pressure";
      sink_random = 1;
      repeat (N_BP) queue_random(2);
      wait_drain();
      sink_random = 0;
      test_name = "throughput";
      check_rate = 1;
      repeat (N_RATE) queue_random(2);
      wait_drain();
      check_rate = 0;
      if (exp_q.size() != 0) begin
         $display("%0d expected results never arrived", exp_q.size());
         end_errs++;
      end
      if (credit_pulses != done_total) begin
         $display("%0d in_credit pulses for %0d results", credit_pulses, done_total);
         end_errs++;
      end
      $display("errors: %0d value, %0d protocol", val_errs,
               proto_errs + sink_errs + credit_viol + end_errs);
      if (val_errs + proto_errs + sink_errs + credit_viol + end_errs == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- hw/fp_add_top.sv
module fp_add_top import fpu_pkg::*; #(
   parameter int OUT_CREDITS = 2
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] a_in,
   input  logic [31:0] b_in,
   input  fp_op_e      op_in,
   input  logic        in_valid,
   input  logic        out_credit,
   output logic        in_credit,
   output logic [31:0] sum_out,
   output logic        overflow_out,
   output logic        out_valid
);

   // per stage load enables
   logic adv1;
   logic adv2;
   logic adv3;

   // stage 1 to stage 2
   logic              sign_shifted;
   logic [FRAC_W-1:0] frac_shifted;
   logic              sign_not_shifted;
   logic [FRAC_W-1:0] frac_not_shifted;
   logic [EXP_W-1:0]  exp_max;

   // stage 2 to stage 3
   logic              sum_sign;
   logic [SUM_W-1:0]  sum_mag;
   logic [EXP_W-1:0]  sum_exp;

   // valid bits and credits live here, stages are datapath only
   fp_add_ctrl #(
      .OUT_CREDITS (OUT_CREDITS)
   ) fp_add_ctrl_inst (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .out_credit (out_credit),
      .adv1       (adv1),
      .adv2       (adv2),
      .adv3       (adv3),
      .out_valid  (out_valid),
      .in_credit  (in_credit)
   );

   fp_add_align fp_add_align_inst (
      .clk              (clk),
      .adv1             (adv1),
      .a_in             (a_in),
      .b_in             (b_in),
      .op_in            (op_in),
      .sign_shifted     (sign_shifted),
      .frac_shifted     (frac_shifted),
      .sign_not_shifted (sign_not_shifted),
      .frac_not_shifted (frac_not_shifted),
      .exp_max          (exp_max)
   );

   fp_add_sum fp_add_sum_inst (
      .clk              (clk),
      .adv2             (adv2),
      .sign_shifted     (sign_shifted),
      .frac_shifted     (frac_shifted),
      .sign_not_shifted (sign_not_shifted),
      .frac_not_shifted (frac_not_shifted),
      .exp_max          (exp_max),
      .sum_sign         (sum_sign),
      .sum_mag          (sum_mag),
      .sum_exp          (sum_exp)
   );

   fp_add_normalize fp_add_normalize_inst (
      .clk          (clk),
      .adv3         (adv3),
      .sum_sign     (sum_sign),
      .sum_mag      (sum_mag),
      .sum_exp      (sum_exp),
      .sum_out      (sum_out),
      .overflow_out (overflow_out)
   );

endmodule

//--- hw/fp_add_normalize.sv
module fp_add_normalize import fpu_pkg::*; (
   input  logic             clk,
   input  logic             adv3,
   input  logic             sum_sign,
   input  logic [SUM_W-1:0] sum_mag,
   input  logic [EXP_W-1:0] sum_exp,
   output logic [31:0]      sum_out,
   output logic             overflow_out
);

   // left shift count that brings the leading one up to bit 25
   logic [4:0]              lead_shift;
   logic                    lead_found;
   logic [SUM_W-1:0]        norm_mag;
   // two extra bits so overflow and underflow are visible
   logic signed [EXP_W+1:0] exp_adj;
   logic [31:0]             next_out;
   logic                    next_ovf;

   // leading one detect over bits 25 down to 0
   always_comb begin
      lead_shift = '0;
      lead_found = 1'b0;
      for (int i = FRAC_W - 1; i >= 0; i--) begin
         if (!lead_found && sum_mag[i]) begin
            lead_shift = 5'(FRAC_W - 1 - i);
            lead_found = 1'b1;
         end
      end
   end

   // normalizing shift and exponent adjust
   always_comb begin
      if (sum_mag[SUM_W-1]) begin
         // carry out, one step right
         norm_mag = sum_mag >> 1;
         exp_adj  = $signed((EXP_W + 2)'(sum_exp)) + 10'sd1;
      end else begin
         norm_mag = sum_mag << lead_shift;
         exp_adj  = $signed((EXP_W + 2)'(sum_exp)) - $signed((EXP_W + 2)'(lead_shift));
      end
   end

   // pack the result, exceptions first
   always_comb begin
      next_ovf = 1'b0;
      if (sum_mag == '0) begin
         // cancellation always gives positive zero
         next_out = 32'h0000_0000;
      end else if (exp_adj >= 255) begin
         // saturate to signed infinity
         next_out = {sum_sign, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
         next_ovf = 1'b1;
      end else if (exp_adj <= 0) begin
         // flush to zero, keep the sign
         next_out = {sum_sign, {(31){1'b0}}};
      end else begin
         // hidden one at bit 25 drops, guard bits truncated
         next_out = {sum_sign, exp_adj[EXP_W-1:0], norm_mag[FRAC_W-2:FRAC_W-1-MANT_W]};
      end
   end

   always_ff @(posedge clk) begin
      if (adv3) begin
         sum_out      <= next_out;
         overflow_out <= next_ovf;
      end
   end

endmodule

//--- hw/fp_add_sum.sv
module fp_add_sum import fpu_pkg::*; (
   input  logic              clk,
   input  logic              adv2,
   input  logic              sign_shifted,
   input  logic [FRAC_W-1:0] frac_shifted,
   input  logic              sign_not_shifted,
   input  logic [FRAC_W-1:0] frac_not_shifted,
   input  logic [EXP_W-1:0]  exp_max,
   output logic              sum_sign,
   output logic [SUM_W-1:0]  sum_mag,
   output logic [EXP_W-1:0]  sum_exp
);

   logic             next_sign;
   logic [SUM_W-1:0] next_mag;
   // zero extended operands, room for the carry
   logic [SUM_W-1:0] mag_s;
   logic [SUM_W-1:0] mag_n;

   assign mag_s = {1'b0, frac_shifted};
   assign mag_n = {1'b0, frac_not_shifted};

   // signed magnitude add or subtract
   always_comb begin
      next_sign = 1'b0;
      next_mag  = '0;
      if (sign_shifted == sign_not_shifted) begin
         // same signs, magnitudes add and may carry into bit 26
         next_sign = sign_not_shifted;
         next_mag  = mag_n + mag_s;
      end else if (mag_n > mag_s) begin
         next_sign = sign_not_shifted;
         next_mag  = mag_n - mag_s;
      end else if (mag_s > mag_n) begin
         // the shifted one can still win when exponents were equal
         next_sign = sign_shifted;
         next_mag  = mag_s - mag_n;
      end
      // exact cancellation falls through as +0
   end

   always_ff @(posedge clk) begin
      if (adv2) begin
         sum_sign <= next_sign;
         sum_mag  <= next_mag;
         // exponent rides along unchanged
         sum_exp  <= exp_max;
      end
   end

endmodule

//--- hw/fp_add_align.sv
module fp_add_align import fpu_pkg::*; (
   input  logic              clk,
   input  logic              adv1,
   input  logic [31:0]       a_in,
   input  logic [31:0]       b_in,
   input  fp_op_e            op_in,
   output logic              sign_shifted,
   output logic [FRAC_W-1:0] frac_shifted,
   output logic              sign_not_shifted,
   output logic [FRAC_W-1:0] frac_not_shifted,
   output logic [EXP_W-1:0]  exp_max
);

   logic             b_sign;
   logic [EXP_W-1:0] a_exp;
   logic [EXP_W-1:0] b_exp;
   // high when b has the larger exponent, so a gets shifted
   logic             shift_a;
   logic [EXP_W-1:0] exp_diff;
   logic [FRAC_W-1:0] a_frac;
   logic [FRAC_W-1:0] b_frac;
   logic [FRAC_W-1:0] shift_src;

   // subtract is add with b negated
   assign b_sign = (op_in == op_sub) ? ~b_in[31] : b_in[31];

   assign a_exp = a_in[30:23];
   assign b_exp = b_in[30:23];

   // equal exponents keep a as the unshifted operand
   assign shift_a = (a_exp < b_exp);

   // unsigned distance between the exponents
   assign exp_diff = shift_a ? (b_exp - a_exp) : (a_exp - b_exp);

   // every exponent field reads with a hidden one, zero and 255 included
   assign a_frac = {1'b1, a_in[MANT_W-1:0], 2'b00};
   assign b_frac = {1'b1, b_in[MANT_W-1:0], 2'b00};

   assign shift_src = shift_a ? a_frac : b_frac;

   // pipeline register, payload only
   always_ff @(posedge clk) begin
      if (adv1) begin
         sign_shifted     <= shift_a ? a_in[31] : b_sign;
         // a distance of 26 or more shifts everything out
         frac_shifted     <= shift_src >> exp_diff;
         sign_not_shifted <= shift_a ? b_sign : a_in[31];
         frac_not_shifted <= shift_a ? b_frac : a_frac;
         // result exponent is the larger of the two
         exp_max          <= shift_a ? b_exp : a_exp;
      end
   end

endmodule

//--- hw/fp_add_ctrl.sv
module fp_add_ctrl #(
   parameter int OUT_CREDITS = 2
) (
   input  logic clk,
   input  logic rst,
   input  logic in_valid,
   input  logic out_credit,
   output logic adv1,
   output logic adv2,
   output logic adv3,
   output logic out_valid,
   output logic in_credit
);

   // counter never holds more than the credits granted at reset
   localparam int CNT_W = $clog2(OUT_CREDITS + 1);

   // stage occupancy
   logic             v1;
   logic             v2;
   logic             v3;
   logic [CNT_W-1:0] credit_cnt;

   // a result leaves when stage 3 is full and the sink has room
   assign out_valid = v3 && (credit_cnt != '0);

   // each result leaving frees one slot for the source
   assign in_credit = out_valid;

   // a stage loads when the next one is empty or moving on
   // this lets bubbles collapse while the output is stalled
   assign adv3 = v2 && (!v3 || out_valid);
   assign adv2 = v1 && (!v2 || adv3);
   assign adv1 = in_valid && (!v1 || adv2);

   always_ff @(posedge clk) begin
      if (rst) begin
         v1 <= 1'b0;
         v2 <= 1'b0;
         v3 <= 1'b0;
      end else begin
         // filled from upstream or held until drained
         v1 <= adv1 || (v1 && !adv2);
         v2 <= adv2 || (v2 && !adv3);
         v3 <= adv3 || (v3 && !out_valid);
      end
   end

   // output credits, grant and spend may land together
   always_ff @(posedge clk) begin
      if (rst) begin
         credit_cnt <= CNT_W'(OUT_CREDITS);
      end else begin
         case ({out_credit, out_valid})
            2'b10:   credit_cnt <= credit_cnt + 1'b1;
            2'b01:   credit_cnt <= credit_cnt - 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

endmodule

//--- hw/fpu_pkg.sv
package fpu_pkg;

   // single precision field layout
   // sign at bit 31, exponent in 30:23, stored fraction in 22:0
   localparam int EXP_W = 8;
   localparam int MANT_W = 23;

   // aligned fraction: hidden one, stored fraction, two guard bits
   localparam int FRAC_W = MANT_W + 3;

   // stage 2 magnitude keeps one carry bit above the aligned fraction
   localparam int SUM_W = FRAC_W + 1;

   // operation that travels with the operands into stage 1
   // subtract only flips the sign of the second operand
   typedef enum logic [0:0] {
      op_add = 1'b0,
      op_sub = 1'b1
   } fp_op_e;

endpackage
